// File: pulp_macros.svh
`ifndef PULP_MACROS_SVH
`define PULP_MACROS_SVH

// bus widths
`define PULP_AW 32
`define PULP_DW 64

// L2 memory region
`define PULP_L2_BASE 32'h1C00_0000
`define PULP_L2_WORDS 512

// cluster windows, one 4 KiB window per cluster
`define PULP_CL_BASE 32'h1000_0000
`define PULP_CL_STRIDE_BITS 12

// per-cluster local memory and register map
// TCDM covers offsets 0x000 to 0x078
`define PULP_TCDM_WORDS 16
`define PULP_CL_COUNT_OFS 12'h080
`define PULP_CL_RESULT_OFS 12'h088

`endif

// File: pulp_pkg.sv
`include "pulp_macros.svh"

package pulp_pkg;

  // plain vectors
  typedef logic [`PULP_AW-1:0] addr_t;
  typedef logic [`PULP_DW-1:0] data_t;
  typedef logic [`PULP_DW/8-1:0] strb_t;
  // one extra bit so a full count of TCDM words fits
  typedef logic [$clog2(`PULP_TCDM_WORDS):0] tcdm_idx_t;

  // single-beat request and response
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  typedef enum logic [1:0] {BUS_IDLE, BUS_FWD, BUS_WAIT, BUS_RESP} bus_state_e;

  typedef enum logic [1:0] {CORE_IDLE, CORE_RUN, CORE_DONE} core_state_e;

  // byte-wise merge of a write into an existing word
  function automatic data_t merge_strb(data_t old_data, data_t new_data, strb_t strb);
    data_t merged;
    merged = old_data;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// File: soc_bus.sv
`timescale 1ns/1ps
`include "pulp_macros.svh"

module soc_bus import pulp_pkg::*; #(
  parameter int unsigned N_CLUSTERS = 2
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  // host side
  input  bus_req_t                         ext_req_i,
  input  logic                             ext_req_valid_i,
  output logic                             ext_req_ready_o,
  output bus_rsp_t                         ext_rsp_o,
  output logic                             ext_rsp_valid_o,
  input  logic                             ext_rsp_ready_i,
  // L2 memory
  output bus_req_t                         l2_req_o,
  output logic                             l2_req_valid_o,
  input  logic                             l2_req_ready_i,
  input  bus_rsp_t                         l2_rsp_i,
  input  logic                             l2_rsp_valid_i,
  output logic                             l2_rsp_ready_o,
  // clusters
  output bus_req_t [N_CLUSTERS-1:0]        cl_req_o,
  output logic     [N_CLUSTERS-1:0]        cl_req_valid_o,
  input  logic     [N_CLUSTERS-1:0]        cl_req_ready_i,
  input  bus_rsp_t [N_CLUSTERS-1:0]        cl_rsp_i,
  input  logic     [N_CLUSTERS-1:0]        cl_rsp_valid_i,
  output logic     [N_CLUSTERS-1:0]        cl_rsp_ready_o
);

  localparam int unsigned CL_IDX_W = (N_CLUSTERS > 1) ? $clog2(N_CLUSTERS) : 1;
  localparam addr_t L2_SPAN = addr_t'(`PULP_L2_WORDS * (`PULP_DW / 8));
  localparam addr_t CL_SPAN = addr_t'(N_CLUSTERS) << `PULP_CL_STRIDE_BITS;

  bus_state_e state_q;
  bus_req_t fwd_req_q;
  bus_rsp_t rsp_q;
  logic sel_l2_q;
  logic [CL_IDX_W-1:0] cl_idx_q;

  addr_t l2_ofs;
  addr_t cl_ofs;
  logic hit_l2;
  logic hit_cl;
  logic accept;

  logic tgt_req_ready;
  logic tgt_rsp_valid;
  bus_rsp_t tgt_rsp;

  // address decode, offsets wrap below the base and miss
  assign l2_ofs = ext_req_i.addr - addr_t'(`PULP_L2_BASE);
  assign cl_ofs = ext_req_i.addr - addr_t'(`PULP_CL_BASE);
  assign hit_l2 = (l2_ofs < L2_SPAN);
  assign hit_cl = (cl_ofs < CL_SPAN);

  assign ext_req_ready_o = (state_q == BUS_IDLE);
  assign accept = ext_req_valid_i && ext_req_ready_o;
  assign ext_rsp_o = rsp_q;
  assign ext_rsp_valid_o = (state_q == BUS_RESP);

  // handshake of the selected target
  always_comb begin
    if (sel_l2_q) begin
      tgt_req_ready = l2_req_ready_i;
      tgt_rsp_valid = l2_rsp_valid_i;
      tgt_rsp = l2_rsp_i;
    end else begin
      tgt_req_ready = cl_req_ready_i[cl_idx_q];
      tgt_rsp_valid = cl_rsp_valid_i[cl_idx_q];
      tgt_rsp = cl_rsp_i[cl_idx_q];
    end
  end

  assign l2_req_o = fwd_req_q;
  assign l2_req_valid_o = (state_q == BUS_FWD) && sel_l2_q;
  assign l2_rsp_ready_o = (state_q == BUS_WAIT) && sel_l2_q;

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : gen_cl_port
    assign cl_req_o[i] = fwd_req_q;
    assign cl_req_valid_o[i] = (state_q == BUS_FWD) && !sel_l2_q &&
                               (cl_idx_q == CL_IDX_W'(i));
    assign cl_rsp_ready_o[i] = (state_q == BUS_WAIT) && !sel_l2_q &&
                               (cl_idx_q == CL_IDX_W'(i));
  end

  // one access at a time
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= BUS_IDLE;
    end else begin
      case (state_q)
        BUS_IDLE: begin
          if (ext_req_valid_i) begin
            state_q <= (hit_l2 || hit_cl) ? BUS_FWD : BUS_RESP;
          end
        end
        BUS_FWD:  if (tgt_req_ready) state_q <= BUS_WAIT;
        BUS_WAIT: if (tgt_rsp_valid) state_q <= BUS_RESP;
        BUS_RESP: if (ext_rsp_ready_i) state_q <= BUS_IDLE;
        default:  state_q <= BUS_IDLE;
      endcase
    end
  end

  // unmapped accesses keep the preset error response
  always_ff @(posedge clk_i) begin
    if (accept) begin
      sel_l2_q <= hit_l2;
      cl_idx_q <= cl_ofs[`PULP_CL_STRIDE_BITS +: CL_IDX_W];
      fwd_req_q <= ext_req_i;
      fwd_req_q.addr <= hit_l2 ? l2_ofs : addr_t'(cl_ofs[`PULP_CL_STRIDE_BITS-1:0]);
      rsp_q <= '{rdata: '0, err: 1'b1};
    end
    if ((state_q == BUS_WAIT) && tgt_rsp_valid) begin
      rsp_q <= tgt_rsp;
    end
  end

endmodule

// File: l2_mem.sv
`timescale 1ns/1ps
`include "pulp_macros.svh"

module l2_mem import pulp_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  bus_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output bus_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i
);

  localparam int unsigned BYTE_OFS = $clog2(`PULP_DW / 8);
  localparam int unsigned IDX_W = $clog2(`PULP_L2_WORDS);

  data_t mem_q [`PULP_L2_WORDS];
  logic [IDX_W-1:0] idx;
  logic accept;
  logic rsp_valid_q;
  bus_rsp_t rsp_q;

  // address is already an offset into L2
  assign idx = req_i.addr[BYTE_OFS +: IDX_W];
  assign req_ready_o = !rsp_valid_q;
  assign accept = req_valid_i && req_ready_o;
  assign rsp_o = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.err <= 1'b0;
      rsp_q.rdata <= req_i.write ? '0 : mem_q[idx];
      if (req_i.write) begin
        mem_q[idx] <= merge_strb(mem_q[idx], req_i.wdata, req_i.strb);
      end
    end
  end

endmodule

// File: cluster_core.sv
`timescale 1ns/1ps

module cluster_core import pulp_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      fetch_en_i,
  input  tcdm_idx_t count_i,
  output tcdm_idx_t tcdm_rd_idx_o,
  input  data_t     tcdm_rd_data_i,
  output data_t     result_o,
  output logic      busy_o,
  output logic      eoc_o
);

  core_state_e state_q;
  logic fetch_en_q;
  logic start;
  logic last;

  tcdm_idx_t idx_q;
  tcdm_idx_t cnt_q;
  data_t acc_q;
  data_t result_q;

  // rising edge of fetch enable, ignored while running
  assign start = fetch_en_i && !fetch_en_q && (state_q != CORE_RUN);
  assign last = (idx_q == cnt_q);

  assign tcdm_rd_idx_o = idx_q;
  assign result_o = result_q;
  assign busy_o = (state_q == CORE_RUN);
  assign eoc_o = (state_q == CORE_DONE);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= CORE_IDLE;
      fetch_en_q <= 1'b0;
      result_q <= '0;
    end else begin
      fetch_en_q <= fetch_en_i;
      case (state_q)
        CORE_IDLE, CORE_DONE: begin
          if (start) begin
            state_q <= CORE_RUN;
          end
        end
        CORE_RUN: begin
          if (last) begin
            result_q <= acc_q;
            state_q <= CORE_DONE;
          end
        end
        default: state_q <= CORE_IDLE;
      endcase
    end
  end

  // walk the TCDM one word per cycle
  always_ff @(posedge clk_i) begin
    if (start) begin
      idx_q <= '0;
      cnt_q <= count_i;
      acc_q <= '0;
    end else if ((state_q == CORE_RUN) && !last) begin
      idx_q <= idx_q + 1'b1;
      // sum wraps modulo 2^64
      acc_q <= acc_q + tcdm_rd_data_i;
    end
  end

endmodule

// File: cluster.sv
`timescale 1ns/1ps
`include "pulp_macros.svh"

module cluster import pulp_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  bus_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output bus_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  input  logic     fetch_en_i,
  output logic     busy_o,
  output logic     eoc_o
);

  localparam int unsigned BYTE_OFS = $clog2(`PULP_DW / 8);
  localparam int unsigned TCDM_IDX_W = $clog2(`PULP_TCDM_WORDS);

  data_t tcdm_q [`PULP_TCDM_WORDS];
  tcdm_idx_t count_q;
  tcdm_idx_t core_rd_idx;
  data_t core_rd_data;
  data_t result;
  data_t count_wr;

  logic [`PULP_CL_STRIDE_BITS-1:0] ofs;
  logic [TCDM_IDX_W-1:0] tcdm_idx;
  logic hit_tcdm;
  logic hit_count;
  logic hit_result;
  logic core_busy;
  logic accept;
  logic rsp_valid_q;
  bus_rsp_t rsp_q;

  // offset decode within the cluster window
  assign ofs = req_i.addr[`PULP_CL_STRIDE_BITS-1:0];
  assign tcdm_idx = ofs[BYTE_OFS +: TCDM_IDX_W];
  assign hit_tcdm = (ofs < (`PULP_CL_STRIDE_BITS)'(`PULP_TCDM_WORDS * (`PULP_DW / 8)));
  assign hit_count = (ofs == `PULP_CL_COUNT_OFS);
  assign hit_result = (ofs == `PULP_CL_RESULT_OFS);

  // core owns the TCDM while it runs
  assign req_ready_o = !rsp_valid_q && !core_busy;
  assign accept = req_valid_i && req_ready_o;
  assign rsp_o = rsp_q;
  assign rsp_valid_o = rsp_valid_q;
  assign busy_o = core_busy;

  assign core_rd_data = tcdm_q[core_rd_idx[TCDM_IDX_W-1:0]];
  assign count_wr = merge_strb(data_t'(count_q), req_i.wdata, req_i.strb);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
      count_q <= '0;
    end else begin
      if (accept) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      // count saturates at the TCDM size
      if (accept && req_i.write && hit_count) begin
        count_q <= (count_wr > data_t'(`PULP_TCDM_WORDS)) ?
                   tcdm_idx_t'(`PULP_TCDM_WORDS) : tcdm_idx_t'(count_wr);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.err <= !(hit_tcdm || hit_count || hit_result);
      rsp_q.rdata <= '0;
      if (!req_i.write) begin
        if (hit_tcdm) begin
          rsp_q.rdata <= tcdm_q[tcdm_idx];
        end else if (hit_count) begin
          rsp_q.rdata <= data_t'(count_q);
        end else if (hit_result) begin
          rsp_q.rdata <= result;
        end
      end
      if (req_i.write && hit_tcdm) begin
        tcdm_q[tcdm_idx] <= merge_strb(tcdm_q[tcdm_idx], req_i.wdata, req_i.strb);
      end
    end
  end

  cluster_core i_core (
    .clk_i,
    .reset_i,
    .fetch_en_i,
    .count_i        (count_q),
    .tcdm_rd_idx_o  (core_rd_idx),
    .tcdm_rd_data_i (core_rd_data),
    .result_o       (result),
    .busy_o         (core_busy),
    .eoc_o
  );

endmodule

// File: pulp_top.sv
`timescale 1ns/1ps

module pulp_top import pulp_pkg::*; #(
  // must be a power of 2
  parameter int unsigned N_CLUSTERS = 2
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // host access
  input  bus_req_t              ext_req_i,
  input  logic                  ext_req_valid_i,
  output logic                  ext_req_ready_o,
  output bus_rsp_t              ext_rsp_o,
  output logic                  ext_rsp_valid_o,
  input  logic                  ext_rsp_ready_i,
  // cluster control
  input  logic [N_CLUSTERS-1:0] cl_fetch_en_i,
  output logic [N_CLUSTERS-1:0] cl_busy_o,
  output logic [N_CLUSTERS-1:0] cl_eoc_o
);

  bus_req_t l2_req;
  logic l2_req_valid;
  logic l2_req_ready;
  bus_rsp_t l2_rsp;
  logic l2_rsp_valid;
  logic l2_rsp_ready;

  bus_req_t [N_CLUSTERS-1:0] cl_req;
  logic [N_CLUSTERS-1:0] cl_req_valid;
  logic [N_CLUSTERS-1:0] cl_req_ready;
  bus_rsp_t [N_CLUSTERS-1:0] cl_rsp;
  logic [N_CLUSTERS-1:0] cl_rsp_valid;
  logic [N_CLUSTERS-1:0] cl_rsp_ready;

  soc_bus #(
    .N_CLUSTERS (N_CLUSTERS)
  ) i_soc_bus (
    .clk_i,
    .reset_i,
    .ext_req_i,
    .ext_req_valid_i,
    .ext_req_ready_o,
    .ext_rsp_o,
    .ext_rsp_valid_o,
    .ext_rsp_ready_i,
    .l2_req_o       (l2_req),
    .l2_req_valid_o (l2_req_valid),
    .l2_req_ready_i (l2_req_ready),
    .l2_rsp_i       (l2_rsp),
    .l2_rsp_valid_i (l2_rsp_valid),
    .l2_rsp_ready_o (l2_rsp_ready),
    .cl_req_o       (cl_req),
    .cl_req_valid_o (cl_req_valid),
    .cl_req_ready_i (cl_req_ready),
    .cl_rsp_i       (cl_rsp),
    .cl_rsp_valid_i (cl_rsp_valid),
    .cl_rsp_ready_o (cl_rsp_ready)
  );

  l2_mem i_l2_mem (
    .clk_i,
    .reset_i,
    .req_i       (l2_req),
    .req_valid_i (l2_req_valid),
    .req_ready_o (l2_req_ready),
    .rsp_o       (l2_rsp),
    .rsp_valid_o (l2_rsp_valid),
    .rsp_ready_i (l2_rsp_ready)
  );

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : gen_clusters
    cluster i_cluster (
      .clk_i,
      .reset_i,
      .req_i       (cl_req[i]),
      .req_valid_i (cl_req_valid[i]),
      .req_ready_o (cl_req_ready[i]),
      .rsp_o       (cl_rsp[i]),
      .rsp_valid_o (cl_rsp_valid[i]),
      .rsp_ready_i (cl_rsp_ready[i]),
      .fetch_en_i  (cl_fetch_en_i[i]),
      .busy_o      (cl_busy_o[i]),
      .eoc_o       (cl_eoc_o[i])
    );
  end

endmodule

// File: pulp_checker.sv
`timescale 1ns/1ps

module pulp_checker import pulp_pkg::*; #(
  parameter int unsigned N_CLUSTERS = 2
) (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  ext_req_valid_i,
  input logic                  ext_req_ready_i,
  input bus_rsp_t              ext_rsp_i,
  input logic                  ext_rsp_valid_i,
  input logic                  ext_rsp_ready_i,
  input logic [N_CLUSTERS-1:0] busy_i,
  input logic [N_CLUSTERS-1:0] eoc_i
);

  // host access open from acceptance until its response is taken
  logic pending_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
    end else if (ext_req_valid_i && ext_req_ready_i) begin
      pending_q <= 1'b1;
    end else if (ext_rsp_valid_i && ext_rsp_ready_i) begin
      pending_q <= 1'b0;
    end
  end

  // host response holds until it is taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    ext_rsp_valid_i && !ext_rsp_ready_i |=> ext_rsp_valid_i && $stable(ext_rsp_i))
    else $error("host response changed before ready");

  assert property (@(posedge clk_i) disable iff (reset_i)
    pending_q |-> !ext_req_ready_i)
    else $error("request ready while a host access is still open");

  // eoc rises in the cycle that busy falls and at no other time
  assert property (@(posedge clk_i) disable iff (reset_i)
    (~busy_i & $past(busy_i)) == (eoc_i & ~$past(eoc_i)))
    else $error("busy and eoc out of step");

  // reset values one cycle after reset is seen
  assert property (@(posedge clk_i)
    reset_i |=> !ext_rsp_valid_i && busy_i == '0 && eoc_i == '0)
    else $error("outputs not cleared by reset");

endmodule

bind pulp_top pulp_checker #(
  .N_CLUSTERS (N_CLUSTERS)
) i_checker (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .ext_req_valid_i (ext_req_valid_i),
  .ext_req_ready_i (ext_req_ready_o),
  .ext_rsp_i       (ext_rsp_o),
  .ext_rsp_valid_i (ext_rsp_valid_o),
  .ext_rsp_ready_i (ext_rsp_ready_i),
  .busy_i          (cl_busy_o),
  .eoc_i           (cl_eoc_o)
);

// File: tb_pulp.sv
`timescale 1ns/1ps
`include "pulp_macros.svh"

module tb_pulp import pulp_pkg::*; ();

  localparam int N_CL = 2;
  localparam int COUNT_OFS = int'(`PULP_CL_COUNT_OFS);
  localparam int RESULT_OFS = int'(`PULP_CL_RESULT_OFS);
  // more than twice the ~1300 cycles that the tests take
  localparam int unsigned CYCLE_LIMIT = 3000;

  logic clk;
  logic reset;
  bus_req_t ext_req;
  logic ext_req_valid;
  logic ext_req_ready;
  bus_rsp_t ext_rsp;
  logic ext_rsp_valid;
  logic ext_rsp_ready;
  logic [N_CL-1:0] fetch_en;
  logic [N_CL-1:0] busy;
  logic [N_CL-1:0] eoc;

  integer seed = 32'h6db312bc;
  int unsigned cycles = 0;

  // reference model of the memories and result registers
  data_t l2_model [`PULP_L2_WORDS];
  data_t tcdm_model [N_CL][`PULP_TCDM_WORDS];
  data_t result_model [N_CL];

  pulp_top #(
    .N_CLUSTERS (N_CL)
  ) DUT (
    .clk_i           (clk),
    .reset_i         (reset),
    .ext_req_i       (ext_req),
    .ext_req_valid_i (ext_req_valid),
    .ext_req_ready_o (ext_req_ready),
    .ext_rsp_o       (ext_rsp),
    .ext_rsp_valid_o (ext_rsp_valid),
    .ext_rsp_ready_i (ext_rsp_ready),
    .cl_fetch_en_i   (fetch_en),
    .cl_busy_o       (busy),
    .cl_eoc_o        (eoc)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  function automatic data_t apply_strobes(data_t old_word, data_t new_word, strb_t strb);
    data_t mask;
    for (int i = 0; i < $bits(strb_t); i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic addr_t l2_addr(int idx);
    return addr_t'(`PULP_L2_BASE + idx * 8);
  endfunction

  function automatic addr_t cl_addr(int c, int ofs);
    return addr_t'(`PULP_CL_BASE + (c << `PULP_CL_STRIDE_BITS) + ofs);
  endfunction

  task automatic expect_equal(string name, data_t exp, data_t got);
    assert (got === exp) else begin
      $display("CHECK FAILED: %s expected 0x%h actual 0x%h", name, exp, got);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic apply_reset();
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  endtask

  // one host access, response accepted after a random delay
  task automatic host_access(input logic is_write, input addr_t addr, input data_t wdata,
                             input strb_t strb, output bus_rsp_t rsp);
    int delay;
    @(posedge clk);
    ext_req <= '{write: is_write, addr: addr, wdata: wdata, strb: strb};
    ext_req_valid <= 1'b1;
    @(negedge clk);
    while (!ext_req_ready) @(negedge clk);
    @(posedge clk);
    ext_req_valid <= 1'b0;
    @(negedge clk);
    while (!ext_rsp_valid) @(negedge clk);
    delay = {$random(seed)} % 4;
    repeat (delay) @(negedge clk);
    rsp = ext_rsp;
    @(posedge clk);
    ext_rsp_ready <= 1'b1;
    @(posedge clk);
    ext_rsp_ready <= 1'b0;
  endtask

  task automatic write_word(addr_t addr, data_t wdata, strb_t strb);
    bus_rsp_t rsp;
    host_access(1'b1, addr, wdata, strb, rsp);
    expect_equal("ext_rsp_o.err", '0, data_t'(rsp.err));
    expect_equal("ext_rsp_o.rdata", '0, rsp.rdata);
  endtask

  task automatic read_expect(addr_t addr, data_t exp);
    bus_rsp_t rsp;
    host_access(1'b0, addr, '0, '0, rsp);
    expect_equal("ext_rsp_o.err", '0, data_t'(rsp.err));
    expect_equal("ext_rsp_o.rdata", exp, rsp.rdata);
  endtask

  // program COUNT, pulse fetch enable and follow busy until eoc
  task automatic run_job(int c, int count);
    data_t expected;
    expected = '0;
    for (int n = 0; n < count; n++) begin
      expected = expected + tcdm_model[c][n];
    end
    write_word(cl_addr(c, COUNT_OFS), data_t'(count), '1);
    @(posedge clk);
    fetch_en[c] <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    expect_equal("cl_busy_o", 64'd1, data_t'(busy[c]));
    expect_equal("cl_eoc_o", '0, data_t'(eoc[c]));
    while (!eoc[c]) begin
      expect_equal("cl_busy_o", 64'd1, data_t'(busy[c]));
      @(negedge clk);
    end
    expect_equal("cl_busy_o", '0, data_t'(busy[c]));
    @(posedge clk);
    fetch_en[c] <= 1'b0;
    read_expect(cl_addr(c, RESULT_OFS), expected);
    result_model[c] = expected;
  endtask

  initial begin
    bus_rsp_t rsp;
    data_t wd;
    data_t sum;
    strb_t st;
    int idx;

    reset = 1'b1;
    ext_req = '0;
    ext_req_valid = 1'b0;
    ext_rsp_ready = 1'b0;
    fetch_en = '0;
    apply_reset();

    // state right after reset
    @(negedge clk);
    expect_equal("cl_busy_o", '0, data_t'(busy));
    expect_equal("cl_eoc_o", '0, data_t'(eoc));
    expect_equal("ext_rsp_valid_o", '0, data_t'(ext_rsp_valid));
    expect_equal("ext_req_ready_o", 64'd1, data_t'(ext_req_ready));
    for (int c = 0; c < N_CL; c++) begin
      read_expect(cl_addr(c, RESULT_OFS), '0);
      result_model[c] = '0;
    end

    // L2 full words, then partial strobes, then read back
    for (int i = 0; i < 8; i++) begin
      idx = (i * 73) % `PULP_L2_WORDS;
      wd = {$random(seed), $random(seed)};
      write_word(l2_addr(idx), wd, '1);
      l2_model[idx] = wd;
    end
    for (int i = 0; i < 8; i++) begin
      idx = (i * 73) % `PULP_L2_WORDS;
      wd = {$random(seed), $random(seed)};
      st = strb_t'($random(seed));
      write_word(l2_addr(idx), wd, st);
      l2_model[idx] = apply_strobes(l2_model[idx], wd, st);
    end
    for (int i = 0; i < 8; i++) begin
      idx = (i * 73) % `PULP_L2_WORDS;
      read_expect(l2_addr(idx), l2_model[idx]);
    end

    // unmapped addresses past the cluster region and past L2
    host_access(1'b1, cl_addr(N_CL, 0), 64'hA5A5_5A5A_DEAD_BEEF, '1, rsp);
    expect_equal("ext_rsp_o.err", 64'd1, data_t'(rsp.err));
    host_access(1'b0, cl_addr(N_CL, 16), '0, '0, rsp);
    expect_equal("ext_rsp_o.err", 64'd1, data_t'(rsp.err));
    expect_equal("ext_rsp_o.rdata", '0, rsp.rdata);
    host_access(1'b0, l2_addr(`PULP_L2_WORDS), '0, '0, rsp);
    expect_equal("ext_rsp_o.err", 64'd1, data_t'(rsp.err));
    expect_equal("ext_rsp_o.rdata", '0, rsp.rdata);
    for (int i = 0; i < 8; i++) begin
      idx = (i * 73) % `PULP_L2_WORDS;
      read_expect(l2_addr(idx), l2_model[idx]);
    end

    // TCDM of both clusters, independent contents
    for (int c = 0; c < N_CL; c++) begin
      for (int w = 0; w < `PULP_TCDM_WORDS; w++) begin
        wd = {$random(seed), $random(seed)};
        write_word(cl_addr(c, w * 8), wd, '1);
        tcdm_model[c][w] = wd;
      end
    end
    wd = {$random(seed), $random(seed)};
    write_word(cl_addr(1, 5 * 8), wd, 8'h3C);
    tcdm_model[1][5] = apply_strobes(tcdm_model[1][5], wd, 8'h3C);
    for (int c = 0; c < N_CL; c++) begin
      for (int w = 0; w < `PULP_TCDM_WORDS; w++) begin
        read_expect(cl_addr(c, w * 8), tcdm_model[c][w]);
      end
    end

    // COUNT saturates at the TCDM size
    write_word(cl_addr(0, COUNT_OFS), 64'd20, '1);
    read_expect(cl_addr(0, COUNT_OFS), 64'd16);
    write_word(cl_addr(1, COUNT_OFS), 64'd7, '1);
    read_expect(cl_addr(1, COUNT_OFS), 64'd7);
    read_expect(cl_addr(0, COUNT_OFS), 64'd16);

    // RESULT ignores writes
    for (int c = 0; c < N_CL; c++) begin
      write_word(cl_addr(c, RESULT_OFS), 64'hFFFF_0000_FFFF_0000, '1);
      read_expect(cl_addr(c, RESULT_OFS), result_model[c]);
    end
    host_access(1'b0, cl_addr(0, 12'h090), '0, '0, rsp);
    expect_equal("ext_rsp_o.err", 64'd1, data_t'(rsp.err));

    // words close to 2^64 so that the sums wrap
    for (int w = 0; w < `PULP_TCDM_WORDS; w++) begin
      wd = (w % 3 == 0) ? 64'hFFFF_FFFF_FFFF_FF00 + w : {$random(seed), $random(seed)};
      write_word(cl_addr(0, w * 8), wd, '1);
      tcdm_model[0][w] = wd;
    end
    run_job(0, 0);
    run_job(0, 5);
    run_job(0, 16);

    // host read to a running cluster stalls until eoc
    write_word(cl_addr(1, COUNT_OFS), 64'd16, '1);
    sum = '0;
    for (int n = 0; n < 16; n++) begin
      sum = sum + tcdm_model[1][n];
    end
    @(posedge clk);
    fetch_en[1] <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    expect_equal("cl_busy_o", 64'd1, data_t'(busy[1]));
    read_expect(cl_addr(1, 3 * 8), tcdm_model[1][3]);
    @(negedge clk);
    expect_equal("cl_eoc_o", 64'd1, data_t'(eoc[1]));
    @(posedge clk);
    fetch_en[1] <= 1'b0;
    read_expect(cl_addr(1, RESULT_OFS), sum);
    result_model[1] = sum;
    read_expect(cl_addr(0, RESULT_OFS), result_model[0]);

    // second reset clears registers, memories keep their contents
    apply_reset();
    @(negedge clk);
    expect_equal("cl_busy_o", '0, data_t'(busy));
    expect_equal("cl_eoc_o", '0, data_t'(eoc));
    expect_equal("ext_rsp_valid_o", '0, data_t'(ext_rsp_valid));
    for (int c = 0; c < N_CL; c++) begin
      read_expect(cl_addr(c, RESULT_OFS), '0);
      read_expect(cl_addr(c, COUNT_OFS), '0);
      read_expect(cl_addr(c, 0), tcdm_model[c][0]);
    end
    read_expect(l2_addr(73), l2_model[73]);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: list.f
+incdir+.
pulp_pkg.sv
soc_bus.sv
l2_mem.sv
cluster_core.sv
cluster.sv
pulp_top.sv
pulp_checker.sv
tb_pulp.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_pulp
FILELIST ?= list.f
PASS_MSG = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
